// ==== hdl/rvPkg.sv ====
package rvPkg;

    typedef logic [31:0] wordT;    // Data, address or instruction word
    typedef logic [4:0]  regIdxT;
    typedef logic [3:0]  aluOpT;
    typedef logic [1:0]  regSrcT;  // Write-back result source
    typedef logic [3:0]  byteEnT;

    localparam aluOpT aluAdd  = 4'd0;
    localparam aluOpT aluSub  = 4'd1;
    localparam aluOpT aluAnd  = 4'd2;
    localparam aluOpT aluOr   = 4'd3;
    localparam aluOpT aluXor  = 4'd4;
    localparam aluOpT aluSll  = 4'd5;
    localparam aluOpT aluSrl  = 4'd6;
    localparam aluOpT aluSra  = 4'd7;
    localparam aluOpT aluSlt  = 4'd8;
    localparam aluOpT aluSltu = 4'd9;

    localparam regSrcT srcAluMem  = 2'd0;  // ALU or load result
    localparam regSrcT srcUimm    = 2'd1;
    localparam regSrcT srcPcImm   = 2'd2;
    localparam regSrcT srcPcPlus4 = 2'd3;

    // Major opcodes, instruction bits 6:2
    localparam logic [4:0] opLoad    = 5'b00000;
    localparam logic [4:0] opMiscMem = 5'b00011;
    localparam logic [4:0] opOpImm   = 5'b00100;
    localparam logic [4:0] opAuipc   = 5'b00101;
    localparam logic [4:0] opStore   = 5'b01000;
    localparam logic [4:0] opOp      = 5'b01100;
    localparam logic [4:0] opLui     = 5'b01101;
    localparam logic [4:0] opBranch  = 5'b11000;
    localparam logic [4:0] opJalr    = 5'b11001;
    localparam logic [4:0] opJal     = 5'b11011;
    localparam logic [4:0] opSystem  = 5'b11100;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  aluOpT op,
    input  wordT  a,
    input  wordT  b,
    output wordT  result,
    output logic  zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only the low five bits shift

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = wordT'($signed(a) >>> shamt);
            aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
            aluSltu: result = {31'b0, a < b};
            default: result = '0;  // Unused codes
        endcase
    end

    // Branch compare reads this after SUB, SLT or SLTU
    assign zero = (result == '0);

endmodule

// ==== hdl/controller.sv ====
`timescale 1ns/1ps

module controller import rvPkg::*; (
    input  wordT       instruction,
    input  logic       ALUZero,
    output aluOpT      ALUCtrl,
    output logic       ALUImm,
    output logic       ALUToPC,
    output logic       branch,
    output logic [1:0] loadSel,
    output logic [1:0] maskSel,
    output logic       memToReg,
    output logic       memWr,
    output regSrcT     regDataSel,
    output logic       regWr,
    output logic       rs2ShiftSel,
    output logic       uext
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       jump;          // Unconditional JAL or JALR
    logic       condBranch;
    logic       branchOnZero;  // Taken when the ALU result is zero

    assign opcode   = instruction[6:2];  // Bits 1:0 are always 11
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];

    // Access size and extension follow funct3 directly
    assign loadSel     = funct3[1:0];
    assign maskSel     = funct3[1:0];
    assign rs2ShiftSel = funct3[0];
    assign uext        = funct3[2];

    assign branch = jump | (condBranch & (branchOnZero ? ALUZero : ~ALUZero));

    always_comb begin
        ALUCtrl      = aluAdd;
        ALUImm       = 1'b0;
        ALUToPC      = 1'b0;
        memToReg     = 1'b0;
        memWr        = 1'b0;
        regDataSel   = srcAluMem;
        regWr        = 1'b0;
        jump         = 1'b0;
        condBranch   = 1'b0;
        branchOnZero = 1'b0;

        case (opcode)
            opOp: begin
                regWr = 1'b1;
                case (funct3)
                    3'b000:  ALUCtrl = funct7b5 ? aluSub : aluAdd;
                    3'b001:  ALUCtrl = aluSll;
                    3'b010:  ALUCtrl = aluSlt;
                    3'b011:  ALUCtrl = aluSltu;
                    3'b100:  ALUCtrl = aluXor;
                    3'b101:  ALUCtrl = funct7b5 ? aluSra : aluSrl;
                    3'b110:  ALUCtrl = aluOr;
                    default: ALUCtrl = aluAnd;
                endcase
            end
            opOpImm: begin
                ALUImm = 1'b1;
                regWr  = 1'b1;
                case (funct3)
                    3'b001:  ALUCtrl = aluSll;
                    3'b010:  ALUCtrl = aluSlt;
                    3'b011:  ALUCtrl = aluSltu;
                    3'b100:  ALUCtrl = aluXor;
                    3'b101:  ALUCtrl = funct7b5 ? aluSra : aluSrl;
                    3'b110:  ALUCtrl = aluOr;
                    3'b111:  ALUCtrl = aluAnd;
                    default: ALUCtrl = aluAdd;  // ADDI
                endcase
            end
            opLoad: begin
                ALUImm   = 1'b1;  // Address is rs1 plus offset
                memToReg = 1'b1;
                regWr    = 1'b1;
            end
            opStore: begin
                ALUImm = 1'b1;
                memWr  = 1'b1;
            end
            opBranch: begin
                condBranch = 1'b1;
                case (funct3)
                    3'b000: begin  // BEQ
                        ALUCtrl      = aluSub;
                        branchOnZero = 1'b1;
                    end
                    3'b001:  ALUCtrl = aluSub;   // BNE
                    3'b100:  ALUCtrl = aluSlt;   // BLT
                    3'b101: begin  // BGE
                        ALUCtrl      = aluSlt;
                        branchOnZero = 1'b1;
                    end
                    3'b110:  ALUCtrl = aluSltu;  // BLTU
                    3'b111: begin  // BGEU
                        ALUCtrl      = aluSltu;
                        branchOnZero = 1'b1;
                    end
                    default: condBranch = 1'b0;  // Reserved encodings
                endcase
            end
            opJalr: begin
                ALUImm     = 1'b1;
                ALUToPC    = 1'b1;  // Target is rs1 plus offset
                jump       = 1'b1;
                regDataSel = srcPcPlus4;
                regWr      = 1'b1;
            end
            opJal: begin
                jump       = 1'b1;
                regDataSel = srcPcPlus4;
                regWr      = 1'b1;
            end
            opLui: begin
                regDataSel = srcUimm;
                regWr      = 1'b1;
            end
            opAuipc: begin
                regDataSel = srcPcImm;
                regWr      = 1'b1;
            end
            opMiscMem, opSystem: ;  // FENCE, ECALL, EBREAK, CSR ops retire as no-ops
            default: ;
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rs1,
    input  regIdxT rs2,
    output wordT   rs1Data,
    output wordT   rs2Data,
    input  logic   we,
    input  regIdxT rd,
    input  wordT   rdData
);

    wordT regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rdData;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage import rvPkg::*; #(
    parameter wordT resetAddr = '0
) (
    input  logic clk,
    input  logic rstN,
    input  logic redirect,
    input  wordT redirectPc,
    output wordT imemAddr,
    input  wordT imemData,
    output logic exValid,
    output wordT exPc,
    output wordT exInstr
);

    wordT pc;

    assign imemAddr = pc;
    assign exInstr  = imemData;  // Synchronous imem read is the fetch register

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= resetAddr;
            exValid <= 1'b0;
        end else begin
            pc      <= redirect ? redirectPc : pc + 32'd4;
            exValid <= ~redirect;  // Kill the wrong-path word
        end
    end

    always_ff @(posedge clk) begin
        exPc <= pc;  // Pairs with the word returning next cycle
    end

    // Redirect targets come from execute and must land on a word boundary
    aRedirectAligned: assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> (redirectPc[1:0] == 2'b00));

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import rvPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       exValid,
    input  wordT       exPc,
    input  wordT       exInstr,
    input  wordT       rs1Data,
    input  wordT       rs2Data,
    input  logic       fwdWe,
    input  regIdxT     fwdRd,
    input  wordT       fwdData,
    output regIdxT     rs1,
    output regIdxT     rs2,
    output logic       redirect,
    output wordT       redirectPc,
    output wordT       dmemAddr,
    output wordT       dmemWdata,
    output byteEnT     dmemByteEn,
    output logic       dmemWe,
    output logic       dmemRe,
    output logic       wbValid,
    output wordT       wbPc,
    output regIdxT     wbRd,
    output logic       wbRegWr,
    output wordT       wbResult,
    output logic       wbMemToReg,
    output logic [1:0] wbLoadSel,
    output logic       wbUext,
    output logic [1:0] wbAddrLow
);

    aluOpT      aluCtrl;
    logic       aluImm, aluToPc, branch, memToReg, memWr, regWr, rs2ShiftSel, uext;
    logic [1:0] loadSel, maskSel;
    regSrcT     regDataSel;
    wordT       immI, immS, immB, immU, immJ, imm;
    wordT       rs1Val, rs2Val, aluResult, pcPlusImm, result;
    logic       aluZero;
    logic [1:0] addrLow;
    byteEnT     storeEn;

    controller uController (
        .instruction(exInstr),
        .ALUZero    (aluZero),
        .ALUCtrl    (aluCtrl),
        .ALUImm     (aluImm),
        .ALUToPC    (aluToPc),
        .branch     (branch),
        .loadSel    (loadSel),
        .maskSel    (maskSel),
        .memToReg   (memToReg),
        .memWr      (memWr),
        .regDataSel (regDataSel),
        .regWr      (regWr),
        .rs2ShiftSel(rs2ShiftSel),
        .uext       (uext)
    );

    assign rs1 = exInstr[19:15];
    assign rs2 = exInstr[24:20];

    // Writeback result bypasses the register file
    assign rs1Val = (fwdWe && fwdRd == rs1 && fwdRd != '0) ? fwdData : rs1Data;
    assign rs2Val = (fwdWe && fwdRd == rs2 && fwdRd != '0) ? fwdData : rs2Data;

    assign immI = {{20{exInstr[31]}}, exInstr[31:20]};
    assign immS = {{20{exInstr[31]}}, exInstr[31:25], exInstr[11:7]};
    assign immB = {{19{exInstr[31]}}, exInstr[31], exInstr[7], exInstr[30:25],
                   exInstr[11:8], 1'b0};
    assign immU = {exInstr[31:12], 12'b0};
    assign immJ = {{11{exInstr[31]}}, exInstr[31], exInstr[19:12], exInstr[20],
                   exInstr[30:21], 1'b0};

    always_comb begin
        case (exInstr[6:2])
            opStore:        imm = immS;
            opBranch:       imm = immB;
            opJal:          imm = immJ;
            opLui, opAuipc: imm = immU;
            default:        imm = immI;
        endcase
    end

    alu uAlu (
        .op    (aluCtrl),
        .a     (rs1Val),
        .b     (aluImm ? imm : rs2Val),
        .result(aluResult),
        .zero  (aluZero)
    );

    assign pcPlusImm  = exPc + imm;
    assign redirect   = exValid & branch;
    assign redirectPc = aluToPc ? {aluResult[31:1], 1'b0} : pcPlusImm;  // JALR clears bit 0

    assign addrLow = aluResult[1:0];

    always_comb begin
        case (maskSel)
            2'd0:    storeEn = byteEnT'(4'b0001 << addrLow);
            2'd1:    storeEn = addrLow[1] ? 4'b1100 : 4'b0011;
            default: storeEn = 4'b1111;
        endcase
    end

    assign dmemAddr   = aluResult;
    assign dmemWe     = exValid & memWr;
    assign dmemRe     = exValid & memToReg;
    assign dmemByteEn = dmemWe ? storeEn : '0;
    assign dmemWdata  = (maskSel == 2'd2) ? rs2Val :
                        rs2ShiftSel ? {2{rs2Val[15:0]}} : {4{rs2Val[7:0]}};

    always_comb begin
        case (regDataSel)
            srcUimm:    result = imm;
            srcPcImm:   result = pcPlusImm;  // AUIPC
            srcPcPlus4: result = exPc + 32'd4;
            default:    result = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid    <= 1'b0;
            wbRegWr    <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbValid    <= exValid;
            wbRegWr    <= regWr;
            wbMemToReg <= memToReg;
        end
    end

    always_ff @(posedge clk) begin
        wbPc      <= exPc;
        wbRd      <= exInstr[11:7];
        wbResult  <= result;
        wbLoadSel <= loadSel;
        wbUext    <= uext;
        wbAddrLow <= addrLow;
    end

    aNoLoadStoreOverlap: assert property (@(posedge clk) disable iff (!rstN)
        !(dmemWe && dmemRe));

endmodule

// ==== hdl/writebackStage.sv ====
`timescale 1ns/1ps

module writebackStage import rvPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       wbValid,
    input  wordT       wbPc,
    input  regIdxT     wbRd,
    input  logic       wbRegWr,
    input  wordT       wbResult,
    input  logic       wbMemToReg,
    input  logic [1:0] wbLoadSel,
    input  logic       wbUext,
    input  logic [1:0] wbAddrLow,
    input  wordT       dmemRdata,
    output logic       rfWe,
    output regIdxT     rfAddr,
    output wordT       rfData,
    output logic       retireValid,
    output wordT       retirePc,
    output regIdxT     retireRd,
    output logic       retireWe,
    output wordT       retireData
);

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    wordT        loadData;

    assign loadByte = dmemRdata[{wbAddrLow, 3'b000} +: 8];
    assign loadHalf = wbAddrLow[1] ? dmemRdata[31:16] : dmemRdata[15:0];

    always_comb begin
        case (wbLoadSel)
            2'd0:    loadData = {{24{~wbUext & loadByte[7]}}, loadByte};
            2'd1:    loadData = {{16{~wbUext & loadHalf[15]}}, loadHalf};
            default: loadData = dmemRdata;
        endcase
    end

    assign rfWe   = wbValid & wbRegWr & (wbRd != '0);  // x0 stays zero
    assign rfAddr = wbRd;
    assign rfData = wbMemToReg ? loadData : wbResult;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireValid <= 1'b0;
            retireWe    <= 1'b0;
        end else begin
            retireValid <= wbValid;
            retireWe    <= rfWe;
        end
    end

    always_ff @(posedge clk) begin
        retirePc   <= wbPc;
        retireRd   <= wbRd;
        retireData <= rfData;
    end

endmodule

// ==== hdl/rvCore.sv ====
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter wordT resetAddr = '0
) (
    input  logic   clk,
    input  logic   rstN,
    output wordT   imemAddr,
    input  wordT   imemData,
    output wordT   dmemAddr,
    output wordT   dmemWdata,
    output byteEnT dmemByteEn,
    output logic   dmemWe,
    output logic   dmemRe,
    input  wordT   dmemRdata,
    output logic   retireValid,
    output wordT   retirePc,
    output regIdxT retireRd,
    output logic   retireWe,
    output wordT   retireData
);

    logic       redirect, exValid, rfWe;
    wordT       redirectPc, exPc, exInstr, rs1Data, rs2Data, rfData;
    regIdxT     rs1, rs2, rfAddr;
    logic       wbValid, wbRegWr, wbMemToReg, wbUext;
    wordT       wbPc, wbResult;
    regIdxT     wbRd;
    logic [1:0] wbLoadSel, wbAddrLow;

    fetchStage #(.resetAddr(resetAddr)) uFetch (
        .clk, .rstN, .redirect, .redirectPc, .imemAddr, .imemData,
        .exValid, .exPc, .exInstr
    );

    executeStage uExecute (
        .clk, .rstN, .exValid, .exPc, .exInstr, .rs1Data, .rs2Data,
        .fwdWe  (rfWe),  // Forwarding taps the register write port
        .fwdRd  (rfAddr),
        .fwdData(rfData),
        .rs1, .rs2, .redirect, .redirectPc,
        .dmemAddr, .dmemWdata, .dmemByteEn, .dmemWe, .dmemRe,
        .wbValid, .wbPc, .wbRd, .wbRegWr, .wbResult, .wbMemToReg,
        .wbLoadSel, .wbUext, .wbAddrLow
    );

    regFile uRegFile (
        .clk, .rstN, .rs1, .rs2, .rs1Data, .rs2Data,
        .we    (rfWe),
        .rd    (rfAddr),
        .rdData(rfData)
    );

    writebackStage uWriteback (
        .clk, .rstN, .wbValid, .wbPc, .wbRd, .wbRegWr, .wbResult, .wbMemToReg,
        .wbLoadSel, .wbUext, .wbAddrLow, .dmemRdata,
        .rfWe, .rfAddr, .rfData,
        .retireValid, .retirePc, .retireRd, .retireWe, .retireData
    );

endmodule

// ==== verification/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();

    localparam int   lastSlot      = 199;  // Self-loop JAL sits here
    localparam wordT resetPc       = '0;
    localparam wordT lastPc        = wordT'(lastSlot * 4);
    localparam int   timeoutCycles = 2000;

    logic   clk = 1'b0;
    logic   rstN;
    wordT   imemAddr, dmemAddr, dmemWdata, retirePc, retireData;
    wordT   imemData = '0;
    wordT   dmemRdata = '0;
    byteEnT dmemByteEn;
    logic   dmemWe, dmemRe, retireValid, retireWe;
    regIdxT retireRd;

    wordT   imem [0:255];
    wordT   dmem [0:255];
    wordT   imemNext = '0;
    wordT   dmemNext = '0;
    wordT   qAddr[$];  // Store requests in the order they reach the port
    wordT   qData[$];
    byteEnT qEn[$];

    wordT   mRegs [0:31];  // Instruction-set model state
    wordT   mMem [0:255];
    wordT   mPc;
    logic   expWe, expStore;
    regIdxT expRd;
    wordT   expData, expNextPc, expStAddr, expStData;
    byteEnT expStEn;

    wordT   rngState = 32'hf5c0;
    logic   done = 1'b0;
    int     retired = 0;
    int     valueErrors = 0;
    int     otherErrors = 0;

    rvCore #(.resetAddr(resetPc)) dut (
        .clk, .rstN, .imemAddr, .imemData,
        .dmemAddr, .dmemWdata, .dmemByteEn, .dmemWe, .dmemRe, .dmemRdata,
        .retireValid, .retirePc, .retireRd, .retireWe, .retireData
    );

    always #10 clk = ~clk;

    function automatic wordT nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic wordT fillWord(int i);
        return (32'(i) * 32'h0101_0101) ^ 32'h5a3c_c3a5;
    endfunction

    function automatic wordT laneMask(byteEnT en);
        return {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
    endfunction

    function automatic wordT encI(logic [11:0] imm, regIdxT rs1, logic [2:0] f3,
                                  regIdxT rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic wordT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1, logic [2:0] f3,
                                  regIdxT rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic wordT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic wordT encB(logic [12:0] imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic wordT encJ(logic [20:0] imm, regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // One random legal instruction using registers x0 to x7
    function automatic wordT genInstr(int slot);
        wordT        r;
        regIdxT      rd, rs1, rs2;
        logic [2:0]  f3;
        logic [1:0]  sz;
        logic [9:0]  off;
        logic [11:0] imm;
        logic [3:0]  kind;
        int          hop;
        r    = nextRandom();
        rd   = {2'b00, r[2:0]};
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        f3   = r[11:9];
        kind = r[15:12];
        imm  = r[27:16];
        hop  = 2 + int'(r[30:28]) % 7;
        sz   = (r[10:9] == 2'b11) ? 2'b10 : r[10:9];
        off  = r[25:16] & ~((10'd1 << sz) - 10'd1);  // Natural alignment
        if (kind >= 4'd12 && kind <= 4'd14 && slot + hop > lastSlot) begin
            kind = 4'd0;  // Target would pass the self-loop
        end
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3: begin
                if (f3 == 3'd1) imm = {7'b0, r[20:16]};
                if (f3 == 3'd5) imm = {1'b0, r[31], 5'b0, r[20:16]};  // SRLI or SRAI
                return encI(imm, rs1, f3, rd, 7'h13);
            end
            4'd4, 4'd5, 4'd6:
                return encR((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[31], 5'b0} : 7'b0,
                            rs2, rs1, f3, rd);
            4'd7:    return {r[31:12], rd, (r[31] ? 7'h37 : 7'h17)};  // LUI or AUIPC
            4'd8, 4'd9:   return encI({2'b00, off}, '0, {r[11] & ~sz[1], sz}, rd, 7'h03);
            4'd10, 4'd11: return encS({2'b00, off}, rs2, '0, {1'b0, sz});
            4'd12, 4'd13:
                return encB(13'(hop * 4), rs2, rs1, (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3);
            4'd14: begin
                if (r[31]) return encJ(21'(hop * 4), rd);
                else return encI(12'((slot + hop) * 4), '0, 3'd0, rd, 7'h67);
            end
            default: return r[31] ? 32'h0ff0000f : 32'h00000073;  // FENCE or ECALL
        endcase
    endfunction

    function automatic wordT aluModel(logic [2:0] f3, logic alt, wordT a, wordT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkRegIdx(string name, regIdxT got, regIdxT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkByteEn(string name, byteEnT got, byteEnT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Executes one instruction at mPc on the architectural state
    task automatic stepModel(wordT instr);
        wordT       a, b, immI, immS, immB, immJ, addr, word;
        logic [2:0] f3;
        logic       wr, taken;
        a    = mRegs[instr[19:15]];
        b    = mRegs[instr[24:20]];
        f3   = instr[14:12];
        immI = {{20{instr[31]}}, instr[31:20]};
        immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        wr        = 1'b0;
        expData   = '0;
        expStore  = 1'b0;
        expNextPc = mPc + 32'd4;
        case (instr[6:0])
            7'h13: begin
                wr      = 1'b1;
                expData = aluModel(f3, f3 == 3'd5 && instr[30], a, immI);
            end
            7'h33: begin
                wr      = 1'b1;
                expData = aluModel(f3, instr[30], a, b);
            end
            7'h37: begin
                wr      = 1'b1;
                expData = {instr[31:12], 12'b0};
            end
            7'h17: begin
                wr      = 1'b1;
                expData = mPc + {instr[31:12], 12'b0};
            end
            7'h03: begin
                wr   = 1'b1;
                addr = a + immI;
                word = mMem[addr[9:2]] >> (8 * addr[1:0]);  // Addressed byte in lane 0
                case (f3)
                    3'd0:    expData = {{24{word[7]}}, word[7:0]};
                    3'd1:    expData = {{16{word[15]}}, word[15:0]};
                    3'd4:    expData = {24'b0, word[7:0]};
                    3'd5:    expData = {16'b0, word[15:0]};
                    default: expData = word;
                endcase
            end
            7'h23: begin
                expStore  = 1'b1;
                expStAddr = a + immS;
                expStData = b << (8 * expStAddr[1:0]);
                case (f3)
                    3'd0:    expStEn = 4'b0001 << expStAddr[1:0];
                    3'd1:    expStEn = 4'b0011 << expStAddr[1:0];
                    default: expStEn = 4'b1111;
                endcase
                for (int i = 0; i < 4; i++) begin
                    if (expStEn[i]) mMem[expStAddr[9:2]][8*i +: 8] = expStData[8*i +: 8];
                end
            end
            7'h63: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) expNextPc = mPc + immB;
            end
            7'h6f: begin
                wr        = 1'b1;
                expData   = mPc + 32'd4;
                expNextPc = mPc + immJ;
            end
            7'h67: begin
                wr        = 1'b1;
                expData   = mPc + 32'd4;
                expNextPc = (a + immI) & ~32'd1;
            end
            default: ;  // FENCE and SYSTEM write nothing
        endcase
        expRd = instr[11:7];
        expWe = wr && (expRd != '0);
        if (expWe) mRegs[expRd] = expData;
    endtask

    task automatic checkStore();
        wordT mask;
        mask = laneMask(expStEn);
        if (qAddr.size() == 0) begin
            otherErrors++;
            $display("Store at pc %h retired but never reached the data port", mPc);
        end else begin
            checkWord("dmemAddr", qAddr.pop_front(), expStAddr);
            checkByteEn("dmemByteEn", qEn.pop_front(), expStEn);
            checkWord("dmemWdata", qData.pop_front() & mask, expStData & mask);
        end
    endtask

    task automatic checkRetire();
        wordT pc;
        pc = mPc;
        checkWord("retirePc", retirePc, pc);
        stepModel(imem[pc[9:2]]);
        checkBit("retireWe", retireWe, expWe);
        if (expWe) begin
            checkRegIdx("retireRd", retireRd, expRd);
            checkWord("retireData", retireData, expData);
        end
        if (expStore) checkStore();
        retired++;
        if (pc == lastPc) done = 1'b1;
        mPc = expNextPc;
    endtask

    // Reset values before the first fetch
    task automatic checkResetState();
        checkWord("imemAddr", imemAddr, resetPc);
        checkBit("retireValid", retireValid, 1'b0);
        checkBit("dmemWe", dmemWe, 1'b0);
        checkBit("dmemRe", dmemRe, 1'b0);
    endtask

    task automatic buildProgram();
        for (int i = 0; i < 256; i++) begin
            if (i < lastSlot) imem[i] = genInstr(i);
            else imem[i] = 32'h00000013;  // NOP padding
            dmem[i] = fillWord(i);
            mMem[i] = fillWord(i);
        end
        imem[lastSlot] = encJ(21'd0, '0);
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        mPc = resetPc;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstN && retireValid && !done) checkRetire();
        imemNext = imem[imemAddr[9:2]];
        if (dmemRe) dmemNext = dmem[dmemAddr[9:2]];
        if (dmemWe) begin
            qAddr.push_back(dmemAddr);
            qEn.push_back(dmemByteEn);
            qData.push_back(dmemWdata);
            for (int i = 0; i < 4; i++) begin
                if (dmemByteEn[i]) dmem[dmemAddr[9:2]][8*i +: 8] = dmemWdata[8*i +: 8];
            end
        end
    end

    // One-cycle read data for both memories
    always @(posedge clk) begin
        #1;
        imemData  = imemNext;
        dmemRdata = dmemNext;
    end

    initial begin
        int cycles;
        rstN   = 1'b0;
        cycles = 0;
        buildProgram();
        repeat (4) @(posedge clk);
        #1;
        checkResetState();
        rstN = 1'b1;
        while (!done && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            otherErrors++;
            $display("Timeout: the self-loop did not retire within %0d cycles", timeoutCycles);
        end
        if (qAddr.size() != 0) begin
            otherErrors++;
            $display("%0d stores reached the data port but never retired", qAddr.size());
        end
        $display("Retired %0d, value errors %0d, other errors %0d",
                 retired, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/rvPkg.sv
hdl/alu.sv
hdl/controller.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/executeStage.sv
hdl/writebackStage.sv
hdl/rvCore.sv
verification/rvCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the rvCore regression with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module rvCoreTb \
    -Mdir obj_dir -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rvCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
